//--- verification/float_trace.txt
// columns: operand a, operand b, op code (0 mul, 1 div, 2 add, 3 sub), expected result
// all values in hex, one operation per line, mantissas truncated
3FC00000 40000000 0 40400000
40400000 3F400000 0 40100000
BF800001 40000001 0 C0000002
BFFFFFFF BFFFFFFF 0 407FFFFE
40A00000 40A00000 0 41C80000
40400000 40000000 1 3FC00000
3F800000 3FC00000 1 3F2AAAAA
3F800000 40400000 1 3EAAAAAA
40E00000 C0400000 1 C0155555
C0C00000 BF000000 1 41400000
3F800000 3F800000 1 3F800000
3FC00000 40000000 2 40600000
3FC00000 3FC00000 2 40400000
3F800001 3F800000 2 40000000
40800000 3F800001 2 40A00000
BFC00000 BFC00000 2 C0400000
3FA00000 BFC00000 2 BE800000
3F800000 C0400000 2 C0000000
40400000 3F800000 3 40000000
3F800008 3F800000 3 35800000
3FC00000 3FA00000 3 3E800000
3F800000 40400000 3 C0000000
BF800000 C0400000 3 40000000
40000000 3F800001 3 3F800000

//--- flist.f
+incdir+src
src/float_pkg.sv
src/float_arith.sv
src/float_norm.sv
src/float_unit.sv
verification/float_unit_checker.sv
verification/float_unit_tb.sv

//--- Makefile
TOP := float_unit_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f src/float_params.svh src/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- verification/float_unit_tb.sv
// testbench for the float unit, replays the operation trace with random idle gaps between starts
`include "float_params.svh"

module float_unit_tb;

	localparam int num_entries      = 24;
	localparam int clk_half         = 20;
	localparam int reset_cycles     = 4;
	localparam int cycles_per_entry = 80;
	localparam int busy_entry       = 6; // gets an extra start pulse while busy

	logic                   in_clk;
	logic                   in_rst;
	logic                   start;
	logic [`FLOAT_BITS-1:0] a;
	logic [`FLOAT_BITS-1:0] b;
	float_pkg::t_op         op;
	logic [`FLOAT_BITS-1:0] result;
	logic                   ready;

	// four words per entry: a, b, op, expected
	logic [`FLOAT_BITS-1:0] trace_mem [0:4*num_entries-1];
	logic [31:0]            lfsr_state;
	int                     done_count = 0;

	float_unit dut (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.start  (start),
		.a      (a),
		.b      (b),
		.op     (op),
		.result (result),
		.ready  (ready)
	);

	always #clk_half in_clk = ~in_clk;

	// a rising ready ends an operation
	always @(posedge ready) begin
		if (!in_rst)
			done_count = done_count + 1;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_idle_gap(output int gap);
		gap = 0;
		for (int k = 0; k < 2; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			gap = (gap << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("Verification failed");
			$fatal(1, "%s does not match its expected value", name);
		end
	endtask

	task automatic wait_for_ready();
		while (ready !== 1'b1)
			@(negedge in_clk);
	endtask

	task automatic run_entry(input int idx);
		logic [31:0] expected;
		int          gap;
		string       name;
		name = $sformatf("entry %0d", idx);
		draw_idle_gap(gap);
		repeat (gap) @(negedge in_clk);
		a        = trace_mem[4*idx];
		b        = trace_mem[4*idx+1];
		op       = float_pkg::t_op'(trace_mem[4*idx+2][1:0]);
		expected = trace_mem[4*idx+3];
		start    = 1'b1;
		@(negedge in_clk);
		start = 1'b0;
		check_value({name, " ready low"}, 32'd0, {31'd0, ready});
		if (idx == busy_entry) begin
			@(negedge in_clk);
			// swapped operands, a wrongly taken start would change the result
			a     = trace_mem[4*idx+1];
			b     = trace_mem[4*idx];
			start = 1'b1; // unit is in normalise here
			@(negedge in_clk);
			start = 1'b0;
			check_value({name, " ready low after busy start"}, 32'd0, {31'd0, ready});
		end
		wait_for_ready();
		check_value({name, " result"}, expected, result);
		check_value({name, " op count"}, idx + 1, done_count);
	endtask

	initial begin
		in_clk     = 1'b0;
		in_rst     = 1'b1;
		start      = 1'b0;
		a          = '0;
		b          = '0;
		op         = float_pkg::op_mul;
		lfsr_state = 32'd96460;
		$readmemh("verification/float_trace.txt", trace_mem);
		repeat (reset_cycles) @(negedge in_clk);
		in_rst = 1'b0;
		check_value("reset ready", 32'd1, {31'd0, ready});
		check_value("reset result", 32'd0, result);
		for (int i = 0; i < num_entries; i++)
			run_entry(i);
		// unit stays idle once the trace is done
		repeat (4) @(negedge in_clk);
		check_value("final ready", 32'd1, {31'd0, ready});
		check_value("final op count", num_entries, done_count);
		$display("Verification passed");
		$finish;
	end

	// watchdog
	initial begin
		#((num_entries * cycles_per_entry + reset_cycles) * 2 * clk_half);
		$display("Verification failed");
		$display("watchdog expired before all trace entries completed");
		$fatal(1, "simulation timed out");
	end

endmodule

//--- verification/float_unit_checker.sv
// start/ready protocol assertions of the float unit, bound into float_unit from this file
`include "float_params.svh"

module float_unit_checker (
	input logic                   in_clk,
	input logic                   in_rst,
	input logic                   start,
	input logic                   ready,
	input logic [`FLOAT_BITS-1:0] result,
	input float_pkg::t_state      state
);

	// idle straight after reset release
	a_ready_after_reset: assert property (@(posedge in_clk) $fell(in_rst) |-> ready)
		else $error("ready is low after reset release");

	a_ready_falls: assert property (@(posedge in_clk) disable iff (in_rst)
		(ready && start) |=> !ready)
		else $error("ready stayed high after an accepted start");

	a_result_stable: assert property (@(posedge in_clk) disable iff (in_rst)
		ready |=> (!ready || $stable(result)))
		else $error("result changed while ready was high");

	a_state_legal: assert property (@(posedge in_clk) disable iff (in_rst)
		state inside {float_pkg::st_idle, float_pkg::st_compute, float_pkg::st_norm})
		else $error("controller state is not legal");

endmodule

bind float_unit float_unit_checker u_checker (
	.in_clk (in_clk),
	.in_rst (in_rst),
	.start  (start),
	.ready  (ready),
	.result (result),
	.state  (state)
);

//--- src/float_unit.sv
// top of the iterative float unit, start/ready controller around arithmetic and normaliser
`include "float_params.svh"

module float_unit (
	input  logic                    in_clk,
	input  logic                    in_rst,
	input  logic                    start,
	input  logic [`FLOAT_BITS-1:0]  a,
	input  logic [`FLOAT_BITS-1:0]  b,
	input  float_pkg::t_op          op,
	output logic [`FLOAT_BITS-1:0]  result,
	output logic                    ready
);

	float_pkg::t_state state;

	logic                          load;
	logic                          norm_start;
	logic                          norm_done;
	logic                          raw_sign;
	logic [`FLOAT_EXP_BITS-1:0]    raw_exp;
	logic [`FLOAT_WIDE_BITS-1:0]   raw_mant;

	assign load  = (state == float_pkg::st_compute);
	assign ready = (state == float_pkg::st_idle);

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state      <= float_pkg::st_idle;
			norm_start <= 1'b0;
		end else begin
			norm_start <= load; // one cycle after load
			case (state)
				float_pkg::st_idle:
					if (start)
						state <= float_pkg::st_compute;
				float_pkg::st_compute:
					state <= float_pkg::st_norm;
				float_pkg::st_norm:
					// norm_done is still high while the normaliser captures
					if (!norm_start && norm_done)
						state <= float_pkg::st_idle;
				default:
					state <= float_pkg::st_idle;
			endcase
		end
	end

	float_arith u_arith (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.load     (load),
		.a        (a),
		.b        (b),
		.op       (op),
		.raw_sign (raw_sign),
		.raw_exp  (raw_exp),
		.raw_mant (raw_mant)
	);

	float_norm u_norm (
		.in_clk     (in_clk),
		.in_rst     (in_rst),
		.norm_start (norm_start),
		.raw_sign   (raw_sign),
		.raw_exp    (raw_exp),
		.raw_mant   (raw_mant),
		.norm_done  (norm_done),
		.result     (result)
	);

endmodule

//--- src/float_norm.sv
// iterative normaliser, shifts the working mantissa one bit per cycle and packs the result
`include "float_params.svh"

module float_norm (
	input  logic                         in_clk,
	input  logic                         in_rst,
	input  logic                         norm_start,
	input  logic                         raw_sign,
	input  logic [`FLOAT_EXP_BITS-1:0]   raw_exp,
	input  logic [`FLOAT_WIDE_BITS-1:0]  raw_mant,
	output logic                         norm_done,
	output logic [`FLOAT_BITS-1:0]       result
);

	logic                         busy;
	logic                         phase_left; // right shifts finished
	logic                         work_sign;
	logic [`FLOAT_EXP_BITS-1:0]   work_exp;
	logic [`FLOAT_WIDE_BITS-1:0]  work_mant;
	logic                         over;
	logic                         under;

	// two or more in fixed point
	assign over = |work_mant[`FLOAT_WIDE_BITS-1:`FLOAT_MANT_BITS+1];

	// fraction left but hidden one missing
	assign under = (work_mant[`FLOAT_MANT_BITS-1:0] != '0) && !work_mant[`FLOAT_MANT_BITS];

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			busy       <= 1'b0;
			phase_left <= 1'b0;
			work_sign  <= 1'b0;
			work_exp   <= '0;
			work_mant  <= '0;
		end else if (norm_start) begin
			busy       <= 1'b1;
			phase_left <= 1'b0;
			work_sign  <= raw_sign;
			work_exp   <= raw_exp;
			work_mant  <= raw_mant;
		end else if (busy) begin
			if (!phase_left) begin
				if (over) begin
					work_mant <= work_mant >> 1;
					work_exp  <= work_exp + 1'b1;
				end else begin
					phase_left <= 1'b1;
				end
			end else if (under) begin
				work_mant <= work_mant << 1;
				work_exp  <= work_exp - 1'b1; // wraps, no underflow check
			end else begin
				busy <= 1'b0;
			end
		end
	end

	assign norm_done = !busy;

	// hidden one dropped
	assign result = {work_sign, work_exp, work_mant[`FLOAT_MANT_BITS-1:0]};

endmodule

//--- src/float_arith.sv
// arithmetic stage of the float unit, registers the raw sign, exponent and mantissa on load
`include "float_params.svh"

module float_arith (
	input  logic                          in_clk,
	input  logic                          in_rst,
	input  logic                          load,
	input  logic [`FLOAT_BITS-1:0]        a,
	input  logic [`FLOAT_BITS-1:0]        b,
	input  float_pkg::t_op                op,
	output logic                          raw_sign,
	output logic [`FLOAT_EXP_BITS-1:0]    raw_exp,
	output logic [`FLOAT_WIDE_BITS-1:0]   raw_mant
);

	localparam logic [`FLOAT_EXP_BITS-1:0] exp_bias   = `FLOAT_EXP_BIAS;
	localparam logic [`FLOAT_EXP_BITS-1:0] mant_shift = `FLOAT_MANT_BITS;

	// unpacked operands, hidden one restored
	logic                        a_sign, b_sign;
	logic [`FLOAT_EXP_BITS-1:0]  a_exp, b_exp;
	logic [`FLOAT_MANT_BITS:0]   a_mant, b_mant;

	// multiply and divide intermediates
	logic [2*`FLOAT_MANT_BITS+1:0] prod;
	logic [2*`FLOAT_MANT_BITS+1:0] prod_shift;
	logic [`FLOAT_WIDE_BITS-1:0]   dividend;
	logic [`FLOAT_WIDE_BITS-1:0]   quotient;

	// add/sub intermediates
	logic                        b_sign_eff;
	logic                        a_is_big;
	logic                        big_sign, small_sign;
	logic [`FLOAT_EXP_BITS-1:0]  big_exp, exp_diff;
	logic [`FLOAT_MANT_BITS:0]   big_mant, small_mant, small_aligned;
	logic [`FLOAT_MANT_BITS+1:0] add_sum;
	logic                        add_sign;

	// selected result before the register
	logic                        next_sign;
	logic [`FLOAT_EXP_BITS-1:0]  next_exp;
	logic [`FLOAT_WIDE_BITS-1:0] next_mant;

	assign a_sign = a[`FLOAT_BITS-1];
	assign b_sign = b[`FLOAT_BITS-1];
	assign a_exp  = a[`FLOAT_BITS-2:`FLOAT_MANT_BITS];
	assign b_exp  = b[`FLOAT_BITS-2:`FLOAT_MANT_BITS];
	assign a_mant = {1'b1, a[`FLOAT_MANT_BITS-1:0]};
	assign b_mant = {1'b1, b[`FLOAT_MANT_BITS-1:0]};

	assign prod       = a_mant * b_mant;
	assign prod_shift = prod >> `FLOAT_MANT_BITS; // back to one integer bit (or two)

	// dividend pre-shifted so the quotient keeps its fraction bits
	assign dividend = {a_mant, {`FLOAT_MANT_BITS{1'b0}}};
	assign quotient = dividend / {{(`FLOAT_WIDE_BITS-`FLOAT_MANT_BITS-1){1'b0}}, b_mant};

	// subtraction is addition with b negated
	assign b_sign_eff = b_sign ^ (op == float_pkg::op_sub);

	// equal exponents keep a as the big operand, shift of zero
	assign a_is_big   = (a_exp >= b_exp);
	assign big_exp    = a_is_big ? a_exp : b_exp;
	assign exp_diff   = a_is_big ? (a_exp - b_exp) : (b_exp - a_exp);
	assign big_mant   = a_is_big ? a_mant : b_mant;
	assign small_mant = a_is_big ? b_mant : a_mant;
	assign big_sign   = a_is_big ? a_sign : b_sign_eff;
	assign small_sign = a_is_big ? b_sign_eff : a_sign;
	assign small_aligned = small_mant >> exp_diff;

	always_comb begin
		if (big_sign == small_sign) begin
			add_sum  = big_mant + small_aligned; // may carry into bit 24
			add_sign = big_sign;
		end else if (big_mant >= small_aligned) begin
			add_sum  = big_mant - small_aligned;
			add_sign = big_sign;
		end else begin
			// only reachable with equal exponents
			add_sum  = small_aligned - big_mant;
			add_sign = small_sign;
		end
	end

	always_comb begin
		case (op)
			float_pkg::op_mul: begin
				next_sign = a_sign ^ b_sign;
				next_exp  = a_exp + b_exp - exp_bias;
				next_mant = prod_shift[`FLOAT_WIDE_BITS-1:0];
			end
			float_pkg::op_div: begin
				next_sign = a_sign ^ b_sign;
				next_exp  = a_exp - b_exp + exp_bias - mant_shift; // normaliser adds it back
				next_mant = {quotient[`FLOAT_WIDE_BITS-`FLOAT_MANT_BITS-1:0],
					{`FLOAT_MANT_BITS{1'b0}}};
			end
			default: begin // add and sub
				next_sign = add_sign;
				next_exp  = big_exp;
				next_mant = {{(`FLOAT_WIDE_BITS-`FLOAT_MANT_BITS-2){1'b0}}, add_sum};
			end
		endcase
	end

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			raw_sign <= 1'b0;
			raw_exp  <= '0;
			raw_mant <= '0;
		end else if (load) begin
			raw_sign <= next_sign;
			raw_exp  <= next_exp;
			raw_mant <= next_mant;
		end
	end

endmodule

//--- src/float_pkg.sv
// shared enumerations of the float unit, referenced by scoped name from rtl and testbench
package float_pkg;

	// operation codes as seen on the op port
	typedef enum logic [1:0] {
		op_mul = 2'b00,
		op_div = 2'b01,
		op_add = 2'b10,
		op_sub = 2'b11
	} t_op;

	// controller states of the top level
	typedef enum logic [1:0] {
		st_idle    = 2'b00, // ready, waiting for start
		st_compute = 2'b01, // arithmetic stage loads
		st_norm    = 2'b10  // normaliser running
	} t_state;

endpackage

//--- src/float_params.svh
// width and bias macros of the single-precision float format, included by rtl and testbench
`ifndef FLOAT_PARAMS_SVH
`define FLOAT_PARAMS_SVH

// whole float word
`define FLOAT_BITS 32

// exponent field and its bias
`define FLOAT_EXP_BITS 8
`define FLOAT_EXP_BIAS 127

`define FLOAT_MANT_BITS 23 // stored fraction, also the product/quotient shift

// working mantissa between arithmetic stage and normaliser
`define FLOAT_WIDE_BITS (2 * `FLOAT_MANT_BITS + 1)

`endif
